/* hdl/sid_settings.svh */
`ifndef SID_SETTINGS_SVH
`define SID_SETTINGS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

`define SID_ADDR_W        5
`define SID_DATA_W        8
`define SID_ACC_W         24
`define SID_WAVE_W        12
`define SID_AUDIO_W       18

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Offsets inside one voice block
`define SID_REG_FREQ_LO   0
`define SID_REG_FREQ_HI   1
`define SID_REG_PW_LO     2
`define SID_REG_PW_HI     3
`define SID_REG_CONTROL   4
`define SID_VOICE_STRIDE  7

`define SID_REG_MODE_VOL  5'h18
`define SID_REG_POT_X     5'h19
`define SID_REG_POT_Y     5'h1a
`define SID_REG_OSC3      5'h1b

// Control byte bits
`define SID_CTL_SYNC      1
`define SID_CTL_RING      2
`define SID_CTL_TEST      3
`define SID_CTL_TRI       4
`define SID_CTL_SAW       5
`define SID_CTL_PULSE     6

`endif

/* hdl/sid_pkg.sv */
`default_nettype none

`include "sid_settings.svh"

package sid_pkg;

	// Bus side
	typedef logic [`SID_ADDR_W-1:0] sid_addr_t;
	typedef logic [`SID_DATA_W-1:0] sid_byte_t;

	// Audio side
	typedef logic [`SID_WAVE_W-1:0] sid_wave_t;
	typedef logic [`SID_AUDIO_W-1:0] sid_audio_t;

	// Stored state of one voice
	typedef struct packed {
		logic [2*`SID_DATA_W-1:0] freq;
		logic [`SID_WAVE_W-1:0]   pw;
		logic [`SID_DATA_W-1:0]   control;
	} sid_voice_regs_t;

endpackage

`default_nettype wire

/* hdl/sid_voice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sid_settings.svh"

module sid_voice (
	input  logic                     clk32,
	input  logic                     reset,
	input  logic                     clk_1mhz,
	input  sid_pkg::sid_voice_regs_t regs,
	input  logic                     msb_in,
	output logic                     msb_out,
	output sid_pkg::sid_wave_t       wave
);

	import sid_pkg::*;

	logic [`SID_ACC_W-1:0] acc;
	logic                  msb_in_d;
	logic                  sync_hit;
	logic                  tri_flip;

	sid_wave_t saw;
	sid_wave_t tri_wave;
	sid_wave_t pulse;

	//////////////////////////////////////////////////
	// Phase accumulator
	//////////////////////////////////////////////////

	assign sync_hit = regs.control[`SID_CTL_SYNC] && msb_in && !msb_in_d;

	always_ff @(posedge clk32) begin
		if (reset) begin
			acc      <= '0;
			msb_in_d <= 1'b0;
		end else begin
			msb_in_d <= msb_in;
			if (regs.control[`SID_CTL_TEST] || sync_hit) begin
				acc <= '0;
			end else if (clk_1mhz) begin
				acc <= acc + `SID_ACC_W'(regs.freq);
			end
		end
	end

	assign msb_out = acc[`SID_ACC_W-1];

	//////////////////////////////////////////////////
	// Waveforms
	//////////////////////////////////////////////////

	// Ring mod swaps the fold point with the previous voice
	assign tri_flip = acc[`SID_ACC_W-1] ^ (regs.control[`SID_CTL_RING] & msb_in);

	assign saw      = acc[`SID_ACC_W-1 -: `SID_WAVE_W];
	assign tri_wave = tri_flip ? ~acc[`SID_ACC_W-2 -: `SID_WAVE_W]
	                           : acc[`SID_ACC_W-2 -: `SID_WAVE_W];
	assign pulse    = (saw >= regs.pw) ? '1 : '0;

	always_comb begin
		wave = '1;
		if (regs.control[`SID_CTL_TRI]) begin
			wave = wave & tri_wave;
		end
		if (regs.control[`SID_CTL_SAW]) begin
			wave = wave & saw;
		end
		if (regs.control[`SID_CTL_PULSE]) begin
			wave = wave & pulse;
		end
		// Silent when nothing selected
		if (!(regs.control[`SID_CTL_TRI] || regs.control[`SID_CTL_SAW] ||
		      regs.control[`SID_CTL_PULSE])) begin
			wave = '0;
		end
	end

endmodule

`default_nettype wire

/* hdl/sid_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sid_settings.svh"

module sid_mixer (
	input  logic                clk32,
	input  logic                reset,
	input  sid_pkg::sid_wave_t  wave1,
	input  sid_pkg::sid_wave_t  wave2,
	input  sid_pkg::sid_wave_t  wave3,
	input  logic [3:0]          volume,
	output sid_pkg::sid_audio_t audio
);

	import sid_pkg::*;

	// Room for three full-scale voices
	logic [`SID_WAVE_W+1:0] sum;

	always_ff @(posedge clk32) begin
		if (reset) begin
			sum   <= '0;
			audio <= '0;
		end else begin
			sum   <= {2'b00, wave1} + {2'b00, wave2} + {2'b00, wave3};
			// Volume applied one stage later
			audio <= sid_audio_t'(sum) * sid_audio_t'(volume);
		end
	end

endmodule

`default_nettype wire

/* hdl/sid_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sid_settings.svh"

module sid_regs (
	input  logic                     clk32,
	input  logic                     reset,
	input  logic                     cs,
	input  logic                     we,
	input  sid_pkg::sid_addr_t       addr,
	input  sid_pkg::sid_byte_t       din,
	input  sid_pkg::sid_byte_t       pot_x,
	input  sid_pkg::sid_byte_t       pot_y,
	input  sid_pkg::sid_wave_t       osc3,
	output sid_pkg::sid_voice_regs_t voice1,
	output sid_pkg::sid_voice_regs_t voice2,
	output sid_pkg::sid_voice_regs_t voice3,
	output logic [3:0]               volume,
	output sid_pkg::sid_byte_t       dout
);

	import sid_pkg::*;

	sid_voice_regs_t vregs [3];
	sid_byte_t       last_wr;

	// Bus address of a register inside voice block n
	function automatic sid_addr_t voice_addr(input int voice, input int offset);
		return sid_addr_t'(voice * `SID_VOICE_STRIDE + offset);
	endfunction

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk32) begin
		if (reset) begin
			for (int v = 0; v < 3; v++) begin
				vregs[v] <= '0;
			end
			volume  <= '0;
			last_wr <= '0;
		end else if (cs && we) begin
			last_wr <= din;
			for (int v = 0; v < 3; v++) begin
				case (addr)
					voice_addr(v, `SID_REG_FREQ_LO): vregs[v].freq[7:0]   <= din;
					voice_addr(v, `SID_REG_FREQ_HI): vregs[v].freq[15:8]  <= din;
					voice_addr(v, `SID_REG_PW_LO):   vregs[v].pw[7:0]     <= din;
					voice_addr(v, `SID_REG_PW_HI):   vregs[v].pw[11:8]    <= din[3:0];
					voice_addr(v, `SID_REG_CONTROL): vregs[v].control     <= din;
					default: ;
				endcase
			end
			// Filter bits of this register are not kept
			if (addr == `SID_REG_MODE_VOL) begin
				volume <= din[3:0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	always_ff @(posedge clk32) begin
		if (reset) begin
			dout <= '0;
		end else if (cs && !we) begin
			case (addr)
				`SID_REG_POT_X: dout <= pot_x;
				`SID_REG_POT_Y: dout <= pot_y;
				`SID_REG_OSC3:  dout <= osc3[`SID_WAVE_W-1 -: `SID_DATA_W];
				default:        dout <= last_wr;
			endcase
		end
	end

	assign voice1 = vregs[0];
	assign voice2 = vregs[1];
	assign voice3 = vregs[2];

endmodule

`default_nettype wire

/* hdl/sid_chip.sv */
`timescale 1ns/1ps
`default_nettype none

module sid_chip (
	input  logic                clk32,
	input  logic                reset,
	input  logic                clk_1mhz,
	input  logic                cs,
	input  logic                we,
	input  sid_pkg::sid_addr_t  addr,
	input  sid_pkg::sid_byte_t  din,
	input  sid_pkg::sid_byte_t  pot_x,
	input  sid_pkg::sid_byte_t  pot_y,
	output sid_pkg::sid_byte_t  dout,
	output sid_pkg::sid_audio_t audio
);

	import sid_pkg::*;

	sid_voice_regs_t voice1_regs;
	sid_voice_regs_t voice2_regs;
	sid_voice_regs_t voice3_regs;
	logic [3:0]      volume;

	sid_wave_t wave1;
	sid_wave_t wave2;
	sid_wave_t wave3;

	logic msb1;
	logic msb2;
	logic msb3;

	// Voice 3 wave also feeds the osc3 readback
	sid_regs u_regs (
		.clk32  (clk32),
		.reset  (reset),
		.cs     (cs),
		.we     (we),
		.addr   (addr),
		.din    (din),
		.pot_x  (pot_x),
		.pot_y  (pot_y),
		.osc3   (wave3),
		.voice1 (voice1_regs),
		.voice2 (voice2_regs),
		.voice3 (voice3_regs),
		.volume (volume),
		.dout   (dout)
	);

	//////////////////////////////////////////////////
	// Voice ring, 3 feeds 1
	//////////////////////////////////////////////////

	sid_voice u_voice1 (
		.clk32    (clk32),
		.reset    (reset),
		.clk_1mhz (clk_1mhz),
		.regs     (voice1_regs),
		.msb_in   (msb3),
		.msb_out  (msb1),
		.wave     (wave1)
	);

	sid_voice u_voice2 (
		.clk32    (clk32),
		.reset    (reset),
		.clk_1mhz (clk_1mhz),
		.regs     (voice2_regs),
		.msb_in   (msb1),
		.msb_out  (msb2),
		.wave     (wave2)
	);

	sid_voice u_voice3 (
		.clk32    (clk32),
		.reset    (reset),
		.clk_1mhz (clk_1mhz),
		.regs     (voice3_regs),
		.msb_in   (msb2),
		.msb_out  (msb3),
		.wave     (wave3)
	);

	sid_mixer u_mixer (
		.clk32  (clk32),
		.reset  (reset),
		.wave1  (wave1),
		.wave2  (wave2),
		.wave3  (wave3),
		.volume (volume),
		.audio  (audio)
	);

endmodule

`default_nettype wire

/* hdl/cbm_sid.sv */
`timescale 1ns/1ps
`default_nettype none

module cbm_sid (
	input  logic                clk32,
	input  logic                reset,
	input  logic                clk_1mhz,

	input  logic                sid1_cs,
	input  logic                sid1_we,
	input  sid_pkg::sid_addr_t  sid1_addr,
	input  sid_pkg::sid_byte_t  sid1_din,
	input  sid_pkg::sid_byte_t  sid1_pot_x,
	input  sid_pkg::sid_byte_t  sid1_pot_y,
	output sid_pkg::sid_byte_t  sid1_dout,
	output sid_pkg::sid_audio_t sid1_audio_data,

	input  logic                sid2_cs,
	input  logic                sid2_we,
	input  sid_pkg::sid_addr_t  sid2_addr,
	input  sid_pkg::sid_byte_t  sid2_din,
	input  sid_pkg::sid_byte_t  sid2_pot_x,
	input  sid_pkg::sid_byte_t  sid2_pot_y,
	output sid_pkg::sid_byte_t  sid2_dout,
	output sid_pkg::sid_audio_t sid2_audio_data
);

	//////////////////////////////////////////////////
	// Chip 1
	//////////////////////////////////////////////////

	sid_chip u_sid1 (
		.clk32    (clk32),
		.reset    (reset),
		.clk_1mhz (clk_1mhz),
		.cs       (sid1_cs),
		.we       (sid1_we),
		.addr     (sid1_addr),
		.din      (sid1_din),
		.pot_x    (sid1_pot_x),
		.pot_y    (sid1_pot_y),
		.dout     (sid1_dout),
		.audio    (sid1_audio_data)
	);

	//////////////////////////////////////////////////
	// Chip 2
	//////////////////////////////////////////////////

	// Separate bus port, same 1 MHz strobe
	sid_chip u_sid2 (
		.clk32    (clk32),
		.reset    (reset),
		.clk_1mhz (clk_1mhz),
		.cs       (sid2_cs),
		.we       (sid2_we),
		.addr     (sid2_addr),
		.din      (sid2_din),
		.pot_x    (sid2_pot_x),
		.pot_y    (sid2_pot_y),
		.dout     (sid2_dout),
		.audio    (sid2_audio_data)
	);

endmodule

`default_nettype wire

/* bench/cbm_sid_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cbm_sid_properties (
	input logic                clk32,
	input logic                reset,
	input logic                sid1_cs,
	input logic                sid1_we,
	input sid_pkg::sid_byte_t  sid1_dout,
	input sid_pkg::sid_audio_t sid1_audio_data,
	input logic                sid2_cs,
	input logic                sid2_we,
	input sid_pkg::sid_byte_t  sid2_dout,
	input sid_pkg::sid_audio_t sid2_audio_data
);

	//////////////////////////////////////////////////
	// Reset values
	//////////////////////////////////////////////////

	reset_clears_1: assert property (@(posedge clk32)
		reset |=> (sid1_dout == '0 && sid1_audio_data == '0))
		else $error("chip 1 outputs not zero after reset");

	reset_clears_2: assert property (@(posedge clk32)
		reset |=> (sid2_dout == '0 && sid2_audio_data == '0))
		else $error("chip 2 outputs not zero after reset");

	//////////////////////////////////////////////////
	// Bus read port
	//////////////////////////////////////////////////

	dout_after_read_1: assert property (@(posedge clk32) disable iff (reset)
		$changed(sid1_dout) |-> ($past(reset) || $past(sid1_cs && !sid1_we)))
		else $error("chip 1 dout changed without a read");

	dout_after_read_2: assert property (@(posedge clk32) disable iff (reset)
		$changed(sid2_dout) |-> ($past(reset) || $past(sid2_cs && !sid2_we)))
		else $error("chip 2 dout changed without a read");

	// Deselected write is ignored
	deselected_write_1: assert property (@(posedge clk32) disable iff (reset)
		(!sid1_cs && sid1_we) |=> $stable(sid1_dout))
		else $error("chip 1 dout changed on a deselected write");

	deselected_write_2: assert property (@(posedge clk32) disable iff (reset)
		(!sid2_cs && sid2_we) |=> $stable(sid2_dout))
		else $error("chip 2 dout changed on a deselected write");

endmodule

bind cbm_sid cbm_sid_properties u_properties (
	.clk32           (clk32),
	.reset           (reset),
	.sid1_cs         (sid1_cs),
	.sid1_we         (sid1_we),
	.sid1_dout       (sid1_dout),
	.sid1_audio_data (sid1_audio_data),
	.sid2_cs         (sid2_cs),
	.sid2_we         (sid2_we),
	.sid2_dout       (sid2_dout),
	.sid2_audio_data (sid2_audio_data)
);

`default_nettype wire

/* bench/cbm_sid_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sid_settings.svh"

module cbm_sid_tb;

	import sid_pkg::*;

	localparam int OP_WR = 0;
	localparam int OP_RD = 1;
	localparam int OP_PEEK = 2;
	localparam int OP_STROBE = 3;
	localparam int OP_AUDIO = 4;
	localparam int OP_IGNORE = 5;
	localparam int ENTRY_CYCLES = 4;
	localparam int V3 = 2 * `SID_VOICE_STRIDE;
	localparam int CTL = `SID_REG_CONTROL;
	localparam int SAW = 1 << `SID_CTL_SAW;
	localparam int TEST = 1 << `SID_CTL_TEST;
	localparam int PULSE = 1 << `SID_CTL_PULSE;
	localparam int VOL = int'(`SID_REG_MODE_VOL);
	localparam int POT1_X = 'h5a;
	localparam int POT1_Y = 'ha7;
	localparam int POT2_X = 'h3c;
	localparam int POT2_Y = 'hc1;

	logic       clk32 = 1'b0;
	logic       reset;
	logic       clk_1mhz;
	logic       sid1_cs;
	logic       sid1_we;
	sid_addr_t  sid1_addr;
	sid_byte_t  sid1_din;
	sid_byte_t  sid1_pot_x;
	sid_byte_t  sid1_pot_y;
	sid_byte_t  sid1_dout;
	sid_audio_t sid1_audio_data;
	logic       sid2_cs;
	logic       sid2_we;
	sid_addr_t  sid2_addr;
	sid_byte_t  sid2_din;
	sid_byte_t  sid2_pot_x;
	sid_byte_t  sid2_pot_y;
	sid_byte_t  sid2_dout;
	sid_audio_t sid2_audio_data;

	// One stimulus table entry per index
	string step_name[$];
	int    step_chip[$];
	int    step_op[$];
	int    step_addr[$];
	int    step_data[$];
	int    step_exp[$];

	int          errors = 0;
	int          checks = 0;
	int          strobe_count = 0;
	int          planned_strobes = 0;
	int          watchdog_cycles = 0;
	bit          table_ready = 1'b0;
	logic [31:0] lcg_state;

	cbm_sid dut (.*);

	always #2 clk32 = ~clk32;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic add_step(input string name, input int chip, input int op,
	                        input int addr, input int data, input int exp);
		step_name.push_back(name);
		step_chip.push_back(chip);
		step_op.push_back(op);
		step_addr.push_back(addr);
		step_data.push_back(data);
		step_exp.push_back(exp);
		if (op == OP_STROBE) begin
			planned_strobes += data;
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic random_byte(output int value);
		lcg_state = lcg_next(lcg_state);
		value = int'(lcg_state[31:24]);
	endtask

	// Sawtooth level after n strobes of frequency f from a cleared accumulator
	function automatic int saw_level(input int n, input int f);
		logic [47:0] acc;
		acc = 48'(n) * 48'(f);
		return int'(acc[23:12]);
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic drive_bus(input int chip, input logic cs, input logic we,
	                         input int addr, input int data);
		if (chip == 1) begin
			sid1_cs = cs;
			sid1_we = we;
			sid1_addr = sid_addr_t'(addr);
			sid1_din = sid_byte_t'(data);
		end else begin
			sid2_cs = cs;
			sid2_we = we;
			sid2_addr = sid_addr_t'(addr);
			sid2_din = sid_byte_t'(data);
		end
	endtask

	task automatic issue_strobes(input int count);
		repeat (count) begin
			clk_1mhz = 1'b1;
			@(negedge clk32);
			clk_1mhz = 1'b0;
			@(negedge clk32);
			strobe_count++;
		end
	endtask

	function automatic logic [31:0] read_dout(input int chip);
		return (chip == 1) ? 32'(sid1_dout) : 32'(sid2_dout);
	endfunction

	function automatic logic [31:0] read_audio(input int chip);
		return (chip == 1) ? 32'(sid1_audio_data) : 32'(sid2_audio_data);
	endfunction

	//////////////////////////////////////////////////
	// Table
	//////////////////////////////////////////////////

	task automatic build_table();
		int b1;
		int b2;
		int b3;
		add_step("reset_dout1", 1, OP_PEEK, 0, 0, 0);
		add_step("reset_dout2", 2, OP_PEEK, 0, 0, 0);
		add_step("reset_audio1", 1, OP_AUDIO, 0, 0, 0);
		add_step("reset_audio2", 2, OP_AUDIO, 0, 0, 0);
		add_step("pot_x1", 1, OP_RD, int'(`SID_REG_POT_X), 0, POT1_X);
		add_step("pot_y1", 1, OP_RD, int'(`SID_REG_POT_Y), 0, POT1_Y);
		add_step("pot_x2", 2, OP_RD, int'(`SID_REG_POT_X), 0, POT2_X);
		add_step("pot_y2", 2, OP_RD, int'(`SID_REG_POT_Y), 0, POT2_Y);
		// Interleaved writes to unused addresses
		random_byte(b1);
		random_byte(b2);
		random_byte(b3);
		add_step("last_wr", 1, OP_WR, 'h1d, b1, 0);
		add_step("last_wr", 2, OP_WR, 'h1e, b2, 0);
		add_step("last_wr", 1, OP_WR, 'h15, b3, 0);
		// Deselected write must not replace the last byte
		add_step("last_wr", 1, OP_IGNORE, 'h1d, b3 ^ 'hff, 0);
		add_step("last_wr1", 1, OP_RD, 'h1c, 0, b3);
		add_step("last_wr2", 2, OP_RD, 'h1f, 0, b2);
		// Voice 3 sawtooth at 0xbeef wraps past 2^24
		add_step("osc3", 1, OP_WR, V3 + CTL, SAW | TEST, 0);
		add_step("osc3", 1, OP_WR, V3 + `SID_REG_FREQ_LO, 'hef, 0);
		add_step("osc3", 1, OP_WR, V3 + `SID_REG_FREQ_HI, 'hbe, 0);
		add_step("osc3", 1, OP_WR, V3 + CTL, SAW, 0);
		add_step("osc3", 1, OP_STROBE, 0, 400, 0);
		add_step("osc3_read", 1, OP_RD, int'(`SID_REG_OSC3), 0, saw_level(400, 'hbeef) >> 4);
		add_step("osc3_mute", 1, OP_WR, V3 + CTL, TEST, 0);
		// Voice 1 alone into the mixer
		add_step("audio", 1, OP_WR, CTL, SAW | TEST, 0);
		add_step("audio", 1, OP_WR, `SID_REG_FREQ_LO, 'h15, 0);
		add_step("audio", 1, OP_WR, `SID_REG_FREQ_HI, 'h7c, 0);
		add_step("audio", 1, OP_WR, VOL, 11, 0);
		add_step("audio", 1, OP_WR, CTL, SAW, 0);
		add_step("audio", 1, OP_STROBE, 0, 150, 0);
		add_step("audio_saw", 1, OP_AUDIO, 0, 0, saw_level(150, 'h7c15) * 11);
		add_step("audio", 1, OP_WR, VOL, 0, 0);
		add_step("audio_vol0", 1, OP_AUDIO, 0, 0, 0);
		// Width 0 keeps the pulse high, even with the accumulator held at zero
		add_step("pulse", 1, OP_WR, CTL, PULSE | TEST, 0);
		add_step("pulse", 1, OP_WR, VOL, 7, 0);
		add_step("pulse_audio", 1, OP_AUDIO, 0, 0, 4095 * 7);
		add_step("pulse", 1, OP_WR, CTL, PULSE, 0);
		add_step("pulse", 1, OP_STROBE, 0, 37, 0);
		add_step("pulse_audio2", 1, OP_AUDIO, 0, 0, 4095 * 7);
		add_step("pulse", 1, OP_IGNORE, VOL, 2, 0);
		add_step("ignored_vol", 1, OP_AUDIO, 0, 0, 4095 * 7);
		add_step("chip2_quiet", 2, OP_AUDIO, 0, 0, 0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int errors_before;
		reset = 1'b1;
		clk_1mhz = 1'b0;
		drive_bus(1, 1'b0, 1'b0, 0, 0);
		drive_bus(2, 1'b0, 1'b0, 0, 0);
		sid1_pot_x = sid_byte_t'(POT1_X);
		sid1_pot_y = sid_byte_t'(POT1_Y);
		sid2_pot_x = sid_byte_t'(POT2_X);
		sid2_pot_y = sid_byte_t'(POT2_Y);
		lcg_state = 32'hcfda2c80;
		build_table();
		watchdog_cycles = 2 * (3 + step_op.size() * ENTRY_CYCLES + 2 * planned_strobes);
		table_ready = 1'b1;
		repeat (3) @(negedge clk32);
		reset = 1'b0;
		for (int i = 0; i < step_op.size(); i++) begin
			errors_before = errors;
			@(negedge clk32);
			case (step_op[i])
				OP_WR: begin
					drive_bus(step_chip[i], 1'b1, 1'b1, step_addr[i], step_data[i]);
					@(negedge clk32);
					drive_bus(step_chip[i], 1'b0, 1'b0, 0, 0);
				end
				OP_IGNORE: begin
					drive_bus(step_chip[i], 1'b0, 1'b1, step_addr[i], step_data[i]);
					@(negedge clk32);
					drive_bus(step_chip[i], 1'b0, 1'b0, 0, 0);
				end
				OP_RD: begin
					drive_bus(step_chip[i], 1'b1, 1'b0, step_addr[i], 0);
					@(negedge clk32);
					drive_bus(step_chip[i], 1'b0, 1'b0, 0, 0);
					check(step_name[i], step_exp[i], read_dout(step_chip[i]));
				end
				OP_PEEK: check(step_name[i], step_exp[i], read_dout(step_chip[i]));
				OP_STROBE: issue_strobes(step_data[i]);
				OP_AUDIO: begin
					// Mixer is two stages deep
					repeat (3) @(negedge clk32);
					check(step_name[i], step_exp[i], read_audio(step_chip[i]));
				end
				default: begin
					$display("step %0d has an unknown operation", i);
					errors++;
				end
			endcase
			if (step_op[i] == OP_RD || step_op[i] == OP_PEEK || step_op[i] == OP_AUDIO) begin
				checks++;
				$display("%s: %s", step_name[i], (errors == errors_before) ? "ok" : "failed");
			end
		end
		$display("%0d checks, %0d errors, %0d strobes", checks, errors, strobe_count);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		wait (table_ready);
		#(watchdog_cycles * 4);
		$display("timeout: the test table did not finish within %0d cycles", watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* cbm_sid.f */
+incdir+hdl
hdl/sid_pkg.sv
hdl/sid_voice.sv
hdl/sid_mixer.sv
hdl/sid_regs.sv
hdl/sid_chip.sv
hdl/cbm_sid.sv
bench/cbm_sid_properties.sv
bench/cbm_sid_tb.sv

/* Makefile */
# Verilator build and run for the dual SID testbench

VERILATOR ?= verilator
TOP       ?= cbm_sid_tb
FILELIST  ?= cbm_sid.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Passes only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)
